/* msx_io_bridge.f */
rtl/msx_io_pkg.sv
rtl/system_ctrl.sv
rtl/msx_mouse.sv
rtl/joystick_ports.sv
rtl/audio_mixer.sv
rtl/sigma_delta_dac.sv
rtl/msx_io_bridge.sv
verif/tb_msx_io_bridge.sv

/* Bender.yml */
package:
  name: msx_io_bridge

sources:
  - rtl/msx_io_pkg.sv
  - rtl/system_ctrl.sv
  - rtl/msx_mouse.sv
  - rtl/joystick_ports.sv
  - rtl/audio_mixer.sv
  - rtl/sigma_delta_dac.sv
  - rtl/msx_io_bridge.sv
  - target: test
    files:
      - verif/tb_msx_io_bridge.sv

/* verif/msx_io_stimulus.txt */
# All fields hex. dip: status exp_dip | rbtn: limit | mount: check_cycle limit | joy: count
# mouse: dx dy buttons exp_xhi exp_xlo exp_yhi exp_ylo | mtimeout: dx dy buttons exp_xhi
# mjoy: host_pattern | audio: vol tape_en tape_in opll opl3_l opl3_r scc1_l scc1_r scc2_l
#   scc2_r pcm psg exp_l exp_r (expected samples after mix and volume shift)
dip 000 fd
dip 1fe 00
dip 02a e8
dip 150 55
dip 200 fd
rbtn 4
mount 64 cd
joy 10
mouse 0a6 0c6 1 2a 2d 26 23
mtimeout 0a6 0c6 1 2a
mjoy 11
audio 7 0 0 0100 0200 0040 0010 7ff0 0000 0020 00 004 0410 0250
audio 4 1 1 1000 0800 0000 0100 0200 0080 0000 02 010 0400 0310
audio 6 1 0 0000 0400 0600 7f00 0000 0000 0100 ff 000 017f 037f
audio 7 0 0 f000 0000 0100 0000 0000 0000 0000 00 000 f000 f100
audio 0 0 0 f000 0000 0100 0000 0000 0000 0000 00 000 ffe0 ffe2

/* verif/tb_msx_io_bridge.sv */
`default_nettype none

module tb_msx_io_bridge;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMG_HOLD = 200;
	localparam int MOUSE_TO = 300;

	logic                       clk_sys = 1'b0;
	logic                       reset;
	logic                       reset_btn;
	logic                       img_mounted;
	msx_io_pkg::status_t        status;
	msx_io_pkg::joy_port_t      host_joy_a;
	msx_io_pkg::joy_port_t      host_joy_b;
	msx_io_pkg::mouse_report_t  mouse;
	logic                       mouse_strobe;
	logic                       msx_stra;
	logic                       msx_strb;
	msx_io_pkg::sound_sources_t sources;
	msx_io_pkg::volume_t        vol;
	logic                       tape_in;
	msx_io_pkg::joy_port_t      msx_joy_a;
	msx_io_pkg::joy_port_t      msx_joy_b;
	logic                       sys_reset;
	msx_io_pkg::dip_t           dip;
	logic                       audio_l;
	logic                       audio_r;
	integer                     seed;
	logic [31:0]                v [0:13]; // Fields of the current command

	always #20 clk_sys = ~clk_sys;

	msx_io_bridge #(
		.IMG_HOLD_CYCLES(IMG_HOLD),
		.MOUSE_TIMEOUT  (MOUSE_TO)
	) uut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.reset_btn_i   (reset_btn),
		.img_mounted_i (img_mounted),
		.status_i      (status),
		.host_joy_a_i  (host_joy_a),
		.host_joy_b_i  (host_joy_b),
		.mouse_i       (mouse),
		.mouse_strobe_i(mouse_strobe),
		.msx_stra_i    (msx_stra),
		.msx_strb_i    (msx_strb),
		.msx_joy_a_o   (msx_joy_a),
		.msx_joy_b_o   (msx_joy_b),
		.sources_i     (sources),
		.vol_i         (vol),
		.tape_in_i     (tape_in),
		.reset_o       (sys_reset),
		.dip_o         (dip),
		.audio_l_o     (audio_l),
		.audio_r_o     (audio_r)
	);

	// Checks and drives happen 5 ns after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped at %0t ns", $time);
	endtask

	task automatic check_joy(input msx_io_pkg::joy_port_t got, input msx_io_pkg::joy_port_t exp,
		input string what);
		if (got !== exp)
			stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_dip(input msx_io_pkg::dip_t got, input msx_io_pkg::dip_t exp,
		input string what);
		if (got !== exp)
			stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// DAC average may be off by one
	task automatic check_sample(input msx_io_pkg::audio_sample_t got,
		input msx_io_pkg::audio_sample_t exp, input string what);
		int diff;
		diff = int'(got) - int'(exp);
		if (diff > 1 || diff < -1)
			stop_run($sformatf("error at %0t ns: %s averages %0d, expected %0d", $time, what,
				got, exp));
	endtask

	task automatic wait_reset_low(input int limit, input string what);
		int n;
		n = 0;
		while (sys_reset !== 1'b0) begin
			if (n == limit)
				stop_run($sformatf("reset_o still high %0d cycles after %s", limit, what));
			next_cycle();
			n++;
		end
	endtask

	// Host levels become strobe gated active low MSX pins
	function automatic msx_io_pkg::joy_port_t expected_pins(input logic [5:0] pressed,
		input logic strobe);
		msx_io_pkg::joy_port_t lvl;
		msx_io_pkg::joy_port_t pins;
		lvl = strobe ? 6'h3f : ~pressed;
		pins[5:4] = lvl[5:4];
		for (int i = 0; i < 4; i++)
			pins[3 - i] = lvl[i];
		return pins;
	endfunction

	task automatic read_fields(input int fd, input int count);
		int code;
		for (int i = 0; i < count; i++) begin
			code = $fscanf(fd, "%h", v[i]);
			if (code != 1)
				stop_run("a line of the stimulus file is missing a field");
		end
	endtask

	task automatic run_joy(input int count);
		logic [31:0] pat_a;
		logic [31:0] pat_b;
		repeat (count) begin
			pat_a = $random(seed);
			pat_b = $random(seed);
			host_joy_a = pat_a[5:0];
			host_joy_b = pat_b[5:0];
			msx_stra = 1'b0; // Strobes in opposite phase
			msx_strb = 1'b1;
			next_cycle();
			check_joy(msx_joy_a, expected_pins(pat_a[5:0], 1'b0), "port A, strobe low");
			check_joy(msx_joy_b, expected_pins(pat_b[5:0], 1'b1), "port B, strobe high");
			msx_stra = 1'b1;
			msx_strb = 1'b0;
			next_cycle();
			check_joy(msx_joy_a, expected_pins(pat_a[5:0], 1'b1), "port A, strobe high");
			check_joy(msx_joy_b, expected_pins(pat_b[5:0], 1'b0), "port B, strobe low");
		end
		host_joy_a = '0;
		host_joy_b = '0;
		msx_stra = 1'b0;
		msx_strb = 1'b0;
		next_cycle();
	endtask

	task automatic send_mouse(input logic [8:0] dx, input logic [8:0] dy, input logic [1:0] btn);
		mouse.dx = dx;
		mouse.dy = dy;
		mouse.buttons = btn;
		host_joy_a = '0;
		mouse_strobe = 1'b1;
		next_cycle();
		mouse_strobe = 1'b0;
		next_cycle();
	endtask

	task automatic toggle_and_check(input msx_io_pkg::joy_port_t exp, input string what);
		msx_stra = ~msx_stra;
		repeat (3) next_cycle();
		check_joy(msx_joy_a, exp, what);
	endtask

	task automatic run_audio();
		int ones_l;
		int ones_r;
		vol = v[0][2:0];
		status[9] = v[1][0]; // Tape enable
		tape_in = v[2][0];
		sources.opll = v[3][15:0];
		sources.opl3_l = v[4][15:0];
		sources.opl3_r = v[5][15:0];
		sources.scc1_l = v[6][14:0];
		sources.scc1_r = v[7][14:0];
		sources.scc2_l = v[8][14:0];
		sources.scc2_r = v[9][14:0];
		sources.pcm = v[10][7:0];
		sources.psg = v[11][8:0];
		repeat (4) next_cycle(); // Mixer pipeline settles
		ones_l = 0;
		ones_r = 0;
		repeat (65536) begin
			next_cycle();
			ones_l += audio_l;
			ones_r += audio_r;
		end
		check_sample(msx_io_pkg::audio_sample_t'(ones_l - 32768), v[12][15:0], "left DAC");
		check_sample(msx_io_pkg::audio_sample_t'(ones_r - 32768), v[13][15:0], "right DAC");
	endtask

	initial begin
		int    fd;
		int    ch;
		string cmd;
		seed = 32'h85bd6b51;
		reset = 1'b1;
		reset_btn = 1'b0;
		img_mounted = 1'b0;
		status = '0;
		host_joy_a = '0;
		host_joy_b = '0;
		mouse = '0;
		mouse_strobe = 1'b0;
		msx_stra = 1'b0;
		msx_strb = 1'b0;
		sources = '0;
		vol = 3'd7;
		tape_in = 1'b0;
		repeat (16) @(posedge clk_sys);
		#5;
		check_bit(sys_reset, 1'b1, "reset_o during reset");
		reset = 1'b0;
		wait_reset_low(4, "reset release");

		fd = $fopen("verif/msx_io_stimulus.txt", "r");
		if (fd == 0)
			stop_run("cannot open the stimulus file verif/msx_io_stimulus.txt");
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd[0] == "#") begin
				ch = 0;
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else if (cmd == "dip") begin
				read_fields(fd, 2);
				status = v[0];
				repeat (2) next_cycle();
				check_dip(dip, v[1][7:0], "dip_o");
			end else if (cmd == "rbtn") begin
				read_fields(fd, 1);
				reset_btn = 1'b1;
				next_cycle();
				check_bit(sys_reset, 1'b1, "reset_o with button pressed");
				reset_btn = 1'b0;
				wait_reset_low(v[0], "button release");
			end else if (cmd == "mount") begin
				read_fields(fd, 2);
				img_mounted = 1'b1;
				next_cycle();
				img_mounted = 1'b0;
				repeat (v[0] - 1) next_cycle();
				check_bit(sys_reset, 1'b1, "reset_o during mount hold-off");
				wait_reset_low(v[1] - v[0], "image mount hold-off");
			end else if (cmd == "joy") begin
				read_fields(fd, 1);
				run_joy(v[0]);
			end else if (cmd == "mouse") begin
				read_fields(fd, 7);
				send_mouse(v[0][8:0], v[1][8:0], v[2][1:0]);
				toggle_and_check(v[3][5:0], "mouse x high nibble");
				toggle_and_check(v[4][5:0], "mouse x low nibble");
				toggle_and_check(v[5][5:0], "mouse y high nibble");
				toggle_and_check(v[6][5:0], "mouse y low nibble");
			end else if (cmd == "mtimeout") begin
				read_fields(fd, 4);
				send_mouse(v[0][8:0], v[1][8:0], v[2][1:0]);
				toggle_and_check(v[3][5:0], "mouse x high nibble");
				msx_stra = ~msx_stra;
				repeat (MOUSE_TO + 20) next_cycle(); // Let the read time out
				toggle_and_check(v[3][5:0], "mouse x high nibble after timeout");
			end else if (cmd == "mjoy") begin
				read_fields(fd, 1);
				host_joy_a = v[0][5:0];
				msx_stra = 1'b0;
				repeat (2) next_cycle();
				check_joy(msx_joy_a, expected_pins(v[0][5:0], 1'b0), "port A after mouse off");
				msx_stra = 1'b1;
				next_cycle();
				check_joy(msx_joy_a, expected_pins(v[0][5:0], 1'b1), "port A, strobe high");
				host_joy_a = '0;
				msx_stra = 1'b0;
				next_cycle();
			end else if (cmd == "audio") begin
				read_fields(fd, 14);
				run_audio();
			end else begin
				stop_run($sformatf("unknown command %s in the stimulus file", cmd));
			end
		end
		$fclose(fd);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/msx_io_bridge.sv */
`default_nettype none

module msx_io_bridge #(
	parameter int IMG_HOLD_CYCLES = 32'h2000000,
	parameter int MOUSE_TIMEOUT = 100000
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         reset_btn_i,
	input  wire                         img_mounted_i,
	input  wire msx_io_pkg::status_t    status_i,
	input  wire msx_io_pkg::joy_port_t  host_joy_a_i,
	input  wire msx_io_pkg::joy_port_t  host_joy_b_i,
	input  wire msx_io_pkg::mouse_report_t mouse_i,
	input  wire                         mouse_strobe_i,
	input  wire                         msx_stra_i,
	input  wire                         msx_strb_i,
	output wire msx_io_pkg::joy_port_t  msx_joy_a_o,
	output wire msx_io_pkg::joy_port_t  msx_joy_b_o,
	input  wire msx_io_pkg::sound_sources_t sources_i,
	input  wire msx_io_pkg::volume_t    vol_i,
	input  wire                         tape_in_i,
	output wire                         reset_o,
	output wire msx_io_pkg::dip_t       dip_o,
	output wire                         audio_l_o,
	output wire                         audio_r_o
);

	wire                       tape_en;
	msx_io_pkg::audio_sample_t mix_l;
	msx_io_pkg::audio_sample_t mix_r;

	system_ctrl #(
		.IMG_HOLD_CYCLES(IMG_HOLD_CYCLES)
	) u_system_ctrl (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.reset_btn_i  (reset_btn_i),
		.img_mounted_i(img_mounted_i),
		.status_i     (status_i),
		.reset_o      (reset_o),
		.dip_o        (dip_o),
		.tape_en_o    (tape_en)
	);

	// Everything below runs on the system reset
	joystick_ports #(
		.MOUSE_TIMEOUT(MOUSE_TIMEOUT)
	) u_joystick_ports (
		.clk_sys       (clk_sys),
		.reset_i       (reset_o),
		.host_joy_a_i  (host_joy_a_i),
		.host_joy_b_i  (host_joy_b_i),
		.mouse_i       (mouse_i),
		.mouse_strobe_i(mouse_strobe_i),
		.msx_stra_i    (msx_stra_i),
		.msx_strb_i    (msx_strb_i),
		.msx_joy_a_o   (msx_joy_a_o),
		.msx_joy_b_o   (msx_joy_b_o)
	);

	audio_mixer u_audio_mixer (
		.clk_sys  (clk_sys),
		.reset_i  (reset_o),
		.sources_i(sources_i),
		.tape_en_i(tape_en),
		.tape_in_i(tape_in_i),
		.vol_i    (vol_i),
		.left_o   (mix_l),
		.right_o  (mix_r)
	);

	sigma_delta_dac #(
		.WIDTH(msx_io_pkg::DAC_WIDTH)
	) u_dac_l (
		.clk_sys (clk_sys),
		.reset_i (reset_o),
		.sample_i(mix_l),
		.dac_o   (audio_l_o)
	);

	sigma_delta_dac #(
		.WIDTH(msx_io_pkg::DAC_WIDTH)
	) u_dac_r (
		.clk_sys (clk_sys),
		.reset_i (reset_o),
		.sample_i(mix_r),
		.dac_o   (audio_r_o)
	);

endmodule

`default_nettype wire

/* rtl/sigma_delta_dac.sv */
`default_nettype none

module sigma_delta_dac #(
	parameter int WIDTH = 16
) (
	input  wire             clk_sys,
	input  wire             reset_i,
	input  wire [WIDTH-1:0] sample_i,
	output logic            dac_o
);

	logic [WIDTH-1:0] offset;
	logic [WIDTH:0]   acc;

	// Signed to offset binary
	assign offset = {~sample_i[WIDTH-1], sample_i[WIDTH-2:0]};

	always_ff @(posedge clk_sys) begin
		if (reset_i)
			acc <= '0;
		else
			acc <= {1'b0, acc[WIDTH-1:0]} + {1'b0, offset};
	end

	// Carry out is the bit stream
	assign dac_o = acc[WIDTH];

endmodule

`default_nettype wire

/* rtl/audio_mixer.sv */
`default_nettype none

module audio_mixer (
	input  wire                         clk_sys,
	input  wire                         reset_i,
	input  wire msx_io_pkg::sound_sources_t sources_i,
	input  wire                         tape_en_i,
	input  wire                         tape_in_i,
	input  wire msx_io_pkg::volume_t    vol_i,
	output msx_io_pkg::audio_sample_t   left_o,
	output msx_io_pkg::audio_sample_t   right_o
);

	msx_io_pkg::audio_sample_t sum_l;
	msx_io_pkg::audio_sample_t sum_r;
	msx_io_pkg::volume_t       vol_q;
	logic                      tape_on;

	// All terms wrap at 16 bits
	function automatic msx_io_pkg::audio_sample_t mix(
		input msx_io_pkg::audio_sample_t opll,
		input logic [15:0]               opl3,
		input msx_io_pkg::scc_sample_t   scc1,
		input msx_io_pkg::scc_sample_t   scc2,
		input msx_io_pkg::pcm_sample_t   pcm,
		input msx_io_pkg::psg_sample_t   psg,
		input logic                      tape
	);
		logic [15:0] acc;
		acc = opll + opl3;
		acc = acc + {scc1[14], scc1} + {scc2[14], scc2};
		acc = acc + {1'b0, psg, 6'b0};
		acc = acc + {pcm, pcm}; // PCM into both bytes
		acc = acc + {8'b0, tape, 7'b0};
		return acc;
	endfunction

	assign tape_on = tape_en_i & tape_in_i;

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			sum_l <= '0;
			sum_r <= '0;
			vol_q <= '0;
		end else begin
			sum_l <= mix(sources_i.opll, sources_i.opl3_l, sources_i.scc1_l, sources_i.scc2_l,
				sources_i.pcm, sources_i.psg, tape_on);
			sum_r <= mix(sources_i.opll, sources_i.opl3_r, sources_i.scc1_r, sources_i.scc2_r,
				sources_i.pcm, sources_i.psg, tape_on);
			vol_q <= vol_i; // Travels with the sum
		end
	end

	// Arithmetic shift keeps the sign
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			left_o <= '0;
			right_o <= '0;
		end else begin
			left_o <= sum_l >>> (3'd7 - vol_q);
			right_o <= sum_r >>> (3'd7 - vol_q);
		end
	end

endmodule

`default_nettype wire

/* rtl/joystick_ports.sv */
`default_nettype none

module joystick_ports #(
	parameter int MOUSE_TIMEOUT = 100000
) (
	input  wire                        clk_sys,
	input  wire                        reset_i,
	input  wire msx_io_pkg::joy_port_t host_joy_a_i,
	input  wire msx_io_pkg::joy_port_t host_joy_b_i,
	input  wire msx_io_pkg::mouse_report_t mouse_i,
	input  wire                        mouse_strobe_i,
	input  wire                        msx_stra_i,
	input  wire                        msx_strb_i,
	output msx_io_pkg::joy_port_t      msx_joy_a_o,
	output msx_io_pkg::joy_port_t      msx_joy_b_o
);

	msx_io_pkg::joy_port_t joy_a_n;
	msx_io_pkg::joy_port_t joy_b_n;
	msx_io_pkg::joy_port_t mouse_pins;
	msx_io_pkg::joy_port_t pins_a;
	msx_io_pkg::joy_port_t pins_b;
	logic                  mouse_en;
	logic                  joy_a_pressed;

	// Direction bits reversed on the core side
	function automatic msx_io_pkg::joy_port_t msx_pin_order(input msx_io_pkg::joy_port_t p);
		return {p[5:4], p[0], p[1], p[2], p[3]};
	endfunction

	assign joy_a_n = ~host_joy_a_i;
	assign joy_b_n = ~host_joy_b_i;
	assign joy_a_pressed = ~&joy_a_n;

	msx_mouse #(
		.MOUSE_TIMEOUT(MOUSE_TIMEOUT)
	) u_mouse (
		.clk_sys        (clk_sys),
		.reset_i        (reset_i),
		.mouse_i        (mouse_i),
		.mouse_strobe_i (mouse_strobe_i),
		.joy_a_pressed_i(joy_a_pressed),
		.msx_stra_i     (msx_stra_i),
		.mouse_en_o     (mouse_en),
		.mouse_pins_o   (mouse_pins)
	);

	// Pressed pin pulls low only while its strobe is low
	assign pins_a = mouse_en ? mouse_pins : (joy_a_n | {6{msx_stra_i}});
	assign pins_b = joy_b_n | {6{msx_strb_i}};

	assign msx_joy_a_o = msx_pin_order(pins_a);
	assign msx_joy_b_o = msx_pin_order(pins_b);

endmodule

`default_nettype wire

/* rtl/msx_mouse.sv */
`default_nettype none

module msx_mouse #(
	parameter int MOUSE_TIMEOUT = 100000
) (
	input  wire                        clk_sys,
	input  wire                        reset_i,
	input  wire msx_io_pkg::mouse_report_t mouse_i,
	input  wire                        mouse_strobe_i,
	input  wire                        joy_a_pressed_i,
	input  wire                        msx_stra_i,
	output logic                       mouse_en_o,
	output msx_io_pkg::joy_port_t      mouse_pins_o
);

	localparam int TO_W = $clog2(MOUSE_TIMEOUT + 1);

	typedef logic [TO_W-1:0] timeout_t;

	typedef enum logic [1:0] {
		NIB_X_HI,
		NIB_X_LO,
		NIB_Y_HI,
		NIB_Y_LO
	} nib_state_e;

	nib_state_e               state;
	logic                     stra_q;
	logic                     advance;
	timeout_t                 timeout_cnt;
	msx_io_pkg::mouse_delta_t x_latch;
	msx_io_pkg::mouse_delta_t y_latch;
	logic [3:0]               nibble;
	logic [1:0]               buttons_n;

	assign advance = mouse_en_o & (stra_q ^ msx_stra_i);
	assign mouse_pins_o = {buttons_n, nibble};

	always_ff @(posedge clk_sys) begin
		if (reset_i)
			mouse_en_o <= 1'b0;
		else if (mouse_strobe_i)
			mouse_en_o <= 1'b1;
		else if (joy_a_pressed_i)
			mouse_en_o <= 1'b0; // Joystick takes the port back
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			state <= NIB_X_HI;
			timeout_cnt <= '0;
		end else if (advance) begin
			timeout_cnt <= timeout_t'(MOUSE_TIMEOUT);
			case (state)
				NIB_X_HI: state <= NIB_X_LO;
				NIB_X_LO: state <= NIB_Y_HI;
				NIB_Y_HI: state <= NIB_Y_LO;
				default:  state <= NIB_X_HI;
			endcase
		end else if (mouse_en_o && timeout_cnt != '0) begin
			timeout_cnt <= timeout_cnt - 1'b1;
			if (timeout_cnt == timeout_t'(1))
				state <= NIB_X_HI; // Host gave up mid-read
		end
	end

	// Nibbles go out MSB of the field on bit 0
	always_ff @(posedge clk_sys) begin
		stra_q <= msx_stra_i;
		buttons_n <= ~mouse_i.buttons;
		if (mouse_strobe_i) begin
			x_latch <= -mouse_i.dx;
			y_latch <= mouse_i.dy;
		end
		if (advance) begin
			case (state)
				NIB_X_HI: nibble <= {x_latch[5], x_latch[6], x_latch[7], x_latch[8]};
				NIB_X_LO: nibble <= {x_latch[1], x_latch[2], x_latch[3], x_latch[4]};
				NIB_Y_HI: nibble <= {y_latch[5], y_latch[6], y_latch[7], y_latch[8]};
				default: begin
					nibble <= {y_latch[1], y_latch[2], y_latch[3], y_latch[4]};
					x_latch <= '0;
					y_latch <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/system_ctrl.sv */
`default_nettype none

module system_ctrl #(
	parameter int IMG_HOLD_CYCLES = 32'h2000000
) (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  reset_btn_i,
	input  wire                  img_mounted_i,
	input  wire msx_io_pkg::status_t status_i,
	output logic                 reset_o,
	output msx_io_pkg::dip_t     dip_o,
	output logic                 tape_en_o
);

	localparam int CNT_W = $clog2(IMG_HOLD_CYCLES + 1);

	typedef logic [CNT_W-1:0] hold_cnt_t;

	localparam hold_cnt_t HOLD_LOAD = hold_cnt_t'(IMG_HOLD_CYCLES);

	hold_cnt_t hold_cnt;
	logic      reset_req;

	// Mount pulse counts as the first hold cycle
	assign reset_req = reset | status_i[0] | reset_btn_i | img_mounted_i | (hold_cnt != '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold_cnt <= '0;
		end else if (img_mounted_i) begin
			hold_cnt <= HOLD_LOAD;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		reset_o <= reset_req;
	end

	// Switch settings reach the core through a reset
	always_ff @(posedge clk_sys) begin
		dip_o <= {~status_i[8], ~status_i[7], ~status_i[6:5], ~status_i[4], ~status_i[3],
			1'b0, ~status_i[1]};
		tape_en_o <= status_i[9];
	end

endmodule

`default_nettype wire

/* rtl/msx_io_pkg.sv */
`default_nettype none

package msx_io_pkg;

	localparam int DAC_WIDTH = 16;

	// One MSX joystick port with active low pins and triggers in 5:4
	typedef logic [5:0] joy_port_t;

	typedef logic [8:0] mouse_delta_t;

	typedef struct packed {
		mouse_delta_t dx;
		mouse_delta_t dy;
		logic [1:0]   buttons; // Active high
	} mouse_report_t;

	// Sound chip outputs
	typedef logic signed [15:0] audio_sample_t;
	typedef logic signed [14:0] scc_sample_t;
	typedef logic [8:0]         psg_sample_t;
	typedef logic signed [7:0]  pcm_sample_t; // Turbo-R PCM

	typedef logic [2:0] volume_t; // 7 is loudest

	typedef struct packed {
		audio_sample_t opll;
		logic [15:0]   opl3_l;
		logic [15:0]   opl3_r;
		scc_sample_t   scc1_l;
		scc_sample_t   scc1_r;
		scc_sample_t   scc2_l;
		scc_sample_t   scc2_r;
		pcm_sample_t   pcm;
		psg_sample_t   psg;
	} sound_sources_t;

	// Host side configuration
	typedef logic [63:0] status_t;
	typedef logic [7:0]  dip_t;

endpackage

`default_nettype wire
